//--- vlog.f
+incdir+rtl
rtl/mem_pkg.sv
rtl/addr_translate.sv
rtl/sram_port.sv
rtl/axi_arbiter.sv
rtl/mem_subsystem_top.sv
testbench/axi_slave_model.sv
testbench/tb_mem_subsystem.sv

//--- testbench/tb_mem_subsystem.sv
`default_nettype none
`include "mem_params.svh"

module tb_mem_subsystem
    import mem_pkg::*;
();

    typedef struct packed {
        logic               on_data;
        logic               with_next;
        logic               no_bus;
        trans_cfg_t         cfg;
        sram_req_t          req;
        fault_e             exp_fault;
        logic [`DATA_W-1:0] exp_rdata;
    } row_t;

    localparam int MAX_ROWS = 32;

    logic       aclk;
    logic       rst_n;
    logic       inst_req;
    sram_req_t  inst_req_data;
    trans_cfg_t inst_cfg;
    logic       inst_addr_ok;
    logic       inst_data_ok;
    sram_rsp_t  inst_rsp;
    logic       data_req;
    sram_req_t  data_req_data;
    trans_cfg_t data_cfg;
    logic       data_addr_ok;
    logic       data_data_ok;
    sram_rsp_t  data_rsp;
    axi_a_t     ar;
    logic       arvalid;
    logic       arready;
    axi_r_t     r;
    logic       rvalid;
    logic       rready;
    axi_a_t     aw;
    logic       awvalid;
    logic       awready;
    axi_w_t     w;
    logic       wvalid;
    logic       wready;
    axi_b_t     b;
    logic       bvalid;
    logic       bready;

    row_t        rows [0:MAX_ROWS-1];
    string       names [0:MAX_ROWS-1];
    int          n_rows;
    int          idx;
    logic        watch_bus;
    int unsigned seed_val;

    mem_subsystem_top dut_i (
        .aclk          (aclk         ),
        .rst_n         (rst_n        ),
        .inst_req      (inst_req     ),
        .inst_req_data (inst_req_data),
        .inst_cfg      (inst_cfg     ),
        .inst_addr_ok  (inst_addr_ok ),
        .inst_data_ok  (inst_data_ok ),
        .inst_rsp      (inst_rsp     ),
        .data_req      (data_req     ),
        .data_req_data (data_req_data),
        .data_cfg      (data_cfg     ),
        .data_addr_ok  (data_addr_ok ),
        .data_data_ok  (data_data_ok ),
        .data_rsp      (data_rsp     ),
        .ar            (ar           ),
        .arvalid       (arvalid      ),
        .arready       (arready      ),
        .r             (r            ),
        .rvalid        (rvalid       ),
        .rready        (rready       ),
        .aw            (aw           ),
        .awvalid       (awvalid      ),
        .awready       (awready      ),
        .w             (w            ),
        .wvalid        (wvalid       ),
        .wready        (wready       ),
        .b             (b            ),
        .bvalid        (bvalid       ),
        .bready        (bready       )
    );

    axi_slave_model slave_i (
        .aclk    (aclk   ),
        .rst_n   (rst_n  ),
        .ar      (ar     ),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r      ),
        .rvalid  (rvalid ),
        .rready  (rready ),
        .aw      (aw     ),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w      ),
        .wvalid  (wvalid ),
        .wready  (wready ),
        .b       (b      ),
        .bvalid  (bvalid ),
        .bready  (bready )
    );

    initial begin
        aclk = 1'b0;
        forever begin
            #10 aclk = ~aclk;
        end
    end

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_rdata(input string name, input logic [`DATA_W-1:0] exp,
                               input logic [`DATA_W-1:0] got);
        if (got !== exp) begin
            $display("[FAIL] %s rdata expected %h actual %h", name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_fault(input string name, input fault_e exp, input fault_e got);
        if (got !== exp) begin
            $display("[FAIL] %s fault expected %0d actual %0d", name, exp, got);
            abort_run();
        end
    endtask

    // a faulted request must not reach the AXI address channels
    always @(negedge aclk) begin
        if (watch_bus && (arvalid || awvalid)) begin
            $display("AXI address valid went high during a translation fault");
            abort_run();
        end
    end

    function automatic dmw_t window(input logic plv0, input logic plv3,
                                    input logic [2:0] pseg, input logic [2:0] vseg);
        return '{plv0: plv0, plv3: plv3, pseg: pseg, vseg: vseg};
    endfunction

    function automatic sram_req_t read_req(input logic [`ADDR_W-1:0] addr);
        return '{op: OP_READ, size: 3'd2, wstrb: 4'h0, addr: addr, wdata: '0};
    endfunction

    function automatic sram_req_t write_req(input logic [`ADDR_W-1:0] addr,
                                            input logic [`DATA_W-1:0] data,
                                            input logic [3:0] strb);
        return '{op: OP_WRITE, size: 3'd2, wstrb: strb, addr: addr, wdata: data};
    endfunction

    task automatic add_row(input string name, input logic on_data, input logic with_next,
                           input logic no_bus, input trans_cfg_t cfg, input sram_req_t req,
                           input fault_e exp_fault, input logic [`DATA_W-1:0] exp_rdata);
        rows[n_rows]  = '{on_data: on_data, with_next: with_next, no_bus: no_bus, cfg: cfg,
                          req: req, exp_fault: exp_fault, exp_rdata: exp_rdata};
        names[n_rows] = name;
        n_rows++;
    endtask

    task automatic load_table();
        trans_cfg_t da;
        trans_cfg_t win0;
        trans_cfg_t win1;
        da   = '{da: 1'b1, plv: 2'd0, dmw0: '0, dmw1: '0};
        // plv0, segment 5 maps onto segment 0
        win0 = '{da: 1'b0, plv: 2'd0, dmw0: window(1'b1, 1'b0, 3'd0, 3'd5), dmw1: '0};
        // plv3, dmw0 closed to this level, dmw1 maps segment 4 onto 0
        win1 = '{da: 1'b0, plv: 2'd3, dmw0: window(1'b1, 1'b0, 3'd0, 3'd5),
                 dmw1: window(1'b0, 1'b1, 3'd0, 3'd4)};
        n_rows = 0;
        add_row("da_write", 1, 0, 0, da, write_req(32'h0000_0100, 32'hcafe_0001, 4'hf),
                FLT_NONE, 32'h0);
        add_row("da_read", 1, 0, 0, da, read_req(32'h0000_0100), FLT_NONE, 32'hcafe_0001);
        add_row("win_seed", 1, 0, 0, da, write_req(32'h0000_0200, 32'h0bad_f00d, 4'hf),
                FLT_NONE, 32'h0);
        add_row("dmw0_read", 1, 0, 0, win0, read_req(32'ha000_0200), FLT_NONE, 32'h0bad_f00d);
        add_row("dmw1_read", 0, 0, 0, win1, read_req(32'h8000_0200), FLT_NONE, 32'h0bad_f00d);
        add_row("miss_read", 1, 0, 1, win0, read_req(32'h6000_0200), FLT_ADDR, 32'h0);
        add_row("plv_read", 0, 0, 1, win1, read_req(32'ha000_0200), FLT_ADDR, 32'h0);
        add_row("miss_write", 1, 0, 1, win0, write_req(32'h6000_0000, 32'hdead_beef, 4'hf),
                FLT_ADDR, 32'h0);
        add_row("pair_seed_a", 1, 0, 0, da, write_req(32'h0000_0400, 32'h1111_aaaa, 4'hf),
                FLT_NONE, 32'h0);
        add_row("pair_seed_b", 1, 0, 0, da, write_req(32'h0000_0404, 32'h2222_bbbb, 4'hf),
                FLT_NONE, 32'h0);
        add_row("pair_inst", 0, 1, 0, da, read_req(32'h0000_0400), FLT_NONE, 32'h1111_aaaa);
        add_row("pair_data", 1, 0, 0, da, read_req(32'h0000_0404), FLT_NONE, 32'h2222_bbbb);
        add_row("err_read", 1, 0, 0, da, read_req(32'hf000_0010), FLT_BUS, 32'h0);
        add_row("err_write", 0, 0, 0, da, write_req(32'hf000_0020, 32'h5555_5555, 4'hf),
                FLT_BUS, 32'h0);
        add_row("strb_old", 1, 0, 0, da, write_req(32'h0000_0300, 32'h1234_5678, 4'hf),
                FLT_NONE, 32'h0);
        add_row("strb_new", 1, 0, 0, da, write_req(32'h0000_0300, 32'haaaa_bbbb, 4'h3),
                FLT_NONE, 32'h0);
        // upper half from the old word, lower half from the new one
        add_row("strb_read", 1, 0, 0, da, read_req(32'h0000_0300), FLT_NONE, 32'h1234_bbbb);
    endtask

    task automatic run_rows(input int first, input int last);
        int        cycles;
        logic      inst_used;
        logic      data_used;
        logic      inst_seen;
        logic      data_seen;
        sram_rsp_t inst_got;
        sram_rsp_t data_got;
        sram_rsp_t got;
        inst_used = 1'b0;
        data_used = 1'b0;
        @(posedge aclk);
        #2;
        for (int k = first; k <= last; k++) begin
            if (rows[k].on_data) begin
                data_used     = 1'b1;
                data_cfg      = rows[k].cfg;
                data_req_data = rows[k].req;
                data_req      = 1'b1;
            end else begin
                inst_used     = 1'b1;
                inst_cfg      = rows[k].cfg;
                inst_req_data = rows[k].req;
                inst_req      = 1'b1;
            end
        end
        watch_bus = rows[first].no_bus;
        cycles = 0;
        forever begin
            @(negedge aclk);
            if ((inst_addr_ok || !inst_used) && (data_addr_ok || !data_used)) begin
                break;
            end
            cycles++;
            if (cycles >= 200) begin
                $display("timed out waiting for addr_ok in %s", names[first]);
                abort_run();
            end
        end
        @(posedge aclk);
        #2;
        inst_req = 1'b0;
        data_req = 1'b0;
        inst_seen = !inst_used;
        data_seen = !data_used;
        cycles = 0;
        while (!(inst_seen && data_seen)) begin
            @(negedge aclk);
            if (inst_data_ok) begin
                inst_seen = 1'b1;
                inst_got  = inst_rsp;
            end
            if (data_data_ok) begin
                data_seen = 1'b1;
                data_got  = data_rsp;
            end
            cycles++;
            if (cycles >= 200 && !(inst_seen && data_seen)) begin
                $display("timed out waiting for data_ok in %s", names[first]);
                abort_run();
            end
        end
        watch_bus = 1'b0;
        for (int k = first; k <= last; k++) begin
            got = rows[k].on_data ? data_got : inst_got;
            check_fault(names[k], rows[k].exp_fault, got.fault);
            check_rdata(names[k], rows[k].exp_rdata, got.rdata);
        end
    endtask

    initial begin
        seed_val      = $urandom(21);
        rst_n         = 1'b0;
        inst_req      = 1'b0;
        inst_req_data = '0;
        inst_cfg      = '0;
        data_req      = 1'b0;
        data_req_data = '0;
        data_cfg      = '0;
        watch_bus     = 1'b0;
        load_table();
        repeat (8) @(posedge aclk);
        #2;
        rst_n = 1'b1;
        @(negedge aclk);
        if (!inst_addr_ok || !data_addr_ok || inst_data_ok || data_data_ok ||
            arvalid || awvalid || wvalid) begin
            $display("port handshake or AXI valid in the wrong state after reset");
            abort_run();
        end
        idx = 0;
        while (idx < n_rows) begin
            if (rows[idx].with_next) begin
                run_rows(idx, idx + 1);
                idx += 2;
            end else begin
                run_rows(idx, idx);
                idx += 1;
            end
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/axi_slave_model.sv
`default_nettype none
`include "mem_params.svh"

module axi_slave_model
    import mem_pkg::*;
(
    input  logic   aclk,
    input  logic   rst_n,
    input  axi_a_t ar,
    input  logic   arvalid,
    output logic   arready,
    output axi_r_t r,
    output logic   rvalid,
    input  logic   rready,
    input  axi_a_t aw,
    input  logic   awvalid,
    output logic   awready,
    input  axi_w_t w,
    input  logic   wvalid,
    output logic   wready,
    output axi_b_t b,
    output logic   bvalid,
    input  logic   bready
);

    logic [`DATA_W-1:0] mem [0:8191];
    axi_a_t             rd_q;
    axi_a_t             aw_q;
    axi_w_t             w_q;
    logic               rd_busy;
    logic               aw_got;
    logic               w_got;
    logic [1:0]         ar_cnt;
    logic [1:0]         r_cnt;
    logic [1:0]         aw_cnt;
    logic [1:0]         w_cnt;

    // top segment bits kept so window translation errors do not alias
    function automatic logic [12:0] word_idx(input logic [`ADDR_W-1:0] addr);
        return {addr[31:29], addr[11:2]};
    endfunction

    function automatic logic bad_addr(input logic [`ADDR_W-1:0] addr);
        return addr[31:28] == 4'hf;
    endfunction

    function automatic logic [1:0] rand_delay();
        logic [31:0] v;
        v = $urandom;
        return v[1:0];
    endfunction

    initial begin
        for (int i = 0; i < 8192; i++) begin
            mem[i] = {i[12:0], 3'b101, ~i[12:0], 3'b010};
        end
    end

    // read side, one burst at a time
    always @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rd_busy <= 1'b0;
            ar_cnt  <= 2'd0;
            r_cnt   <= 2'd0;
            rd_q    <= '0;
            r       <= '0;
        end else begin
            arready <= 1'b0;
            if (arvalid && arready) begin
                rd_q    <= ar;
                rd_busy <= 1'b1;
                ar_cnt  <= rand_delay();
                r_cnt   <= rand_delay();
            end else if (arvalid && !rd_busy) begin
                if (ar_cnt == 2'd0) begin
                    arready <= 1'b1;
                end else begin
                    ar_cnt <= ar_cnt - 2'd1;
                end
            end
            if (rvalid && rready) begin
                rvalid  <= 1'b0;
                rd_busy <= 1'b0;
            end else if (rd_busy && !rvalid) begin
                if (r_cnt == 2'd0) begin
                    rvalid <= 1'b1;
                    r      <= '{id: rd_q.id,
                                data: bad_addr(rd_q.addr) ? '0 : mem[word_idx(rd_q.addr)],
                                resp: bad_addr(rd_q.addr) ? 2'd2 : 2'd0,
                                last: 1'b1};
                end else begin
                    r_cnt <= r_cnt - 2'd1;
                end
            end
        end
    end

    // write side, aw and w taken independently
    always @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            aw_cnt  <= 2'd0;
            w_cnt   <= 2'd0;
            aw_q    <= '0;
            w_q     <= '0;
            b       <= '0;
        end else begin
            awready <= 1'b0;
            wready  <= 1'b0;
            if (awvalid && awready) begin
                aw_q   <= aw;
                aw_got <= 1'b1;
                aw_cnt <= rand_delay();
            end else if (awvalid && !aw_got) begin
                if (aw_cnt == 2'd0) begin
                    awready <= 1'b1;
                end else begin
                    aw_cnt <= aw_cnt - 2'd1;
                end
            end
            if (wvalid && wready) begin
                w_q   <= w;
                w_got <= 1'b1;
                w_cnt <= rand_delay();
            end else if (wvalid && !w_got) begin
                if (w_cnt == 2'd0) begin
                    wready <= 1'b1;
                end else begin
                    w_cnt <= w_cnt - 2'd1;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                aw_got <= 1'b0;
                w_got  <= 1'b0;
            end else if (aw_got && w_got && !bvalid) begin
                if (!bad_addr(aw_q.addr)) begin
                    for (int k = 0; k < 4; k++) begin
                        if (w_q.strb[k]) begin
                            mem[word_idx(aw_q.addr)][8*k +: 8] <= w_q.data[8*k +: 8];
                        end
                    end
                end
                bvalid <= 1'b1;
                b      <= '{id: aw_q.id, resp: bad_addr(aw_q.addr) ? 2'd2 : 2'd0};
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/mem_subsystem_top.sv
`default_nettype none

module mem_subsystem_top
    import mem_pkg::*;
(
    input  logic       aclk,
    input  logic       rst_n,
    // inst side
    input  logic       inst_req,
    input  sram_req_t  inst_req_data,
    input  trans_cfg_t inst_cfg,
    output logic       inst_addr_ok,
    output logic       inst_data_ok,
    output sram_rsp_t  inst_rsp,
    // data side
    input  logic       data_req,
    input  sram_req_t  data_req_data,
    input  trans_cfg_t data_cfg,
    output logic       data_addr_ok,
    output logic       data_data_ok,
    output sram_rsp_t  data_rsp,
    // axi
    output axi_a_t     ar,
    output logic       arvalid,
    input  logic       arready,
    input  axi_r_t     r,
    input  logic       rvalid,
    output logic       rready,
    output axi_a_t     aw,
    output logic       awvalid,
    input  logic       awready,
    output axi_w_t     w,
    output logic       wvalid,
    input  logic       wready,
    input  axi_b_t     b,
    input  logic       bvalid,
    output logic       bready
);

    logic      inst_bus_req;
    logic      data_bus_req;
    sram_req_t inst_bus_data;
    sram_req_t data_bus_data;
    logic      inst_gnt;
    logic      data_gnt;
    logic      inst_done;
    logic      data_done;
    sram_rsp_t inst_bus_rsp;
    sram_rsp_t data_bus_rsp;

    sram_port inst_port_i (
        .aclk     (aclk         ),
        .rst_n    (rst_n        ),
        .req      (inst_req     ),
        .req_data (inst_req_data),
        .cfg      (inst_cfg     ),
        .addr_ok  (inst_addr_ok ),
        .data_ok  (inst_data_ok ),
        .rsp      (inst_rsp     ),
        .bus_req  (inst_bus_req ),
        .bus_data (inst_bus_data),
        .bus_gnt  (inst_gnt     ),
        .bus_done (inst_done    ),
        .bus_rsp  (inst_bus_rsp )
    );

    sram_port data_port_i (
        .aclk     (aclk         ),
        .rst_n    (rst_n        ),
        .req      (data_req     ),
        .req_data (data_req_data),
        .cfg      (data_cfg     ),
        .addr_ok  (data_addr_ok ),
        .data_ok  (data_data_ok ),
        .rsp      (data_rsp     ),
        .bus_req  (data_bus_req ),
        .bus_data (data_bus_data),
        .bus_gnt  (data_gnt     ),
        .bus_done (data_done    ),
        .bus_rsp  (data_bus_rsp )
    );

    axi_arbiter arb_i (
        .aclk      (aclk         ),
        .rst_n     (rst_n        ),
        .inst_req  (inst_bus_req ),
        .data_req  (data_bus_req ),
        .inst_data (inst_bus_data),
        .data_data (data_bus_data),
        .inst_gnt  (inst_gnt     ),
        .data_gnt  (data_gnt     ),
        .inst_done (inst_done    ),
        .data_done (data_done    ),
        .inst_rsp  (inst_bus_rsp ),
        .data_rsp  (data_bus_rsp ),
        .ar        (ar           ),
        .arvalid   (arvalid      ),
        .arready   (arready      ),
        .r         (r            ),
        .rvalid    (rvalid       ),
        .rready    (rready       ),
        .aw        (aw           ),
        .awvalid   (awvalid      ),
        .awready   (awready      ),
        .w         (w            ),
        .wvalid    (wvalid       ),
        .wready    (wready       ),
        .b         (b            ),
        .bvalid    (bvalid       ),
        .bready    (bready       )
    );

endmodule

`default_nettype wire

//--- rtl/axi_arbiter.sv
`default_nettype none
`include "mem_params.svh"

module axi_arbiter
    import mem_pkg::*;
(
    input  logic      aclk,
    input  logic      rst_n,
    input  logic      inst_req,
    input  logic      data_req,
    input  sram_req_t inst_data,
    input  sram_req_t data_data,
    output logic      inst_gnt,
    output logic      data_gnt,
    output logic      inst_done,
    output logic      data_done,
    output sram_rsp_t inst_rsp,
    output sram_rsp_t data_rsp,
    output axi_a_t    ar,
    output logic      arvalid,
    input  logic      arready,
    input  axi_r_t    r,
    input  logic      rvalid,
    output logic      rready,
    output axi_a_t    aw,
    output logic      awvalid,
    input  logic      awready,
    output axi_w_t    w,
    output logic      wvalid,
    input  logic      wready,
    input  axi_b_t    b,
    input  logic      bvalid,
    output logic      bready
);

    logic                 inst_rd;
    logic                 inst_wr;
    logic                 data_rd;
    logic                 data_wr;
    logic                 rd_launch;
    logic                 wr_launch;
    logic                 rd_inst;
    logic                 wr_inst;
    sram_req_t            rd_sel;
    sram_req_t            wr_sel;
    logic [`AXI_ID_W-1:0] rd_id;
    logic [`AXI_ID_W-1:0] wr_id;

    function automatic fault_e resp_fault(input logic [`RESP_W-1:0] resp);
        return (resp == '0) ? FLT_NONE : FLT_BUS;
    endfunction

    function automatic logic rsp_hit(input logic [`AXI_ID_W-1:0] id);
        return (rvalid && r.last && r.id == id) || (bvalid && b.id == id);
    endfunction

    function automatic sram_rsp_t rsp_pick(input logic [`AXI_ID_W-1:0] id);
        sram_rsp_t rsp_v;
        rsp_v.rdata = '0;
        rsp_v.fault = FLT_NONE;
        if (rvalid && r.id == id) begin
            rsp_v.rdata = r.data;
            rsp_v.fault = resp_fault(r.resp);
        end else if (bvalid && b.id == id) begin
            rsp_v.fault = resp_fault(b.resp);
        end
        return rsp_v;
    endfunction

    assign inst_rd = inst_req && (inst_data.op == OP_READ);
    assign inst_wr = inst_req && (inst_data.op == OP_WRITE);
    assign data_rd = data_req && (data_data.op == OP_READ);
    assign data_wr = data_req && (data_data.op == OP_WRITE);

    // data side has fixed priority on both channels
    assign rd_inst   = !data_rd;
    assign wr_inst   = !data_wr;
    assign rd_launch = !arvalid && (inst_rd || data_rd);
    assign wr_launch = !awvalid && !wvalid && (inst_wr || data_wr);

    assign rd_sel = rd_inst ? inst_data : data_data;
    assign wr_sel = wr_inst ? inst_data : data_data;
    assign rd_id  = rd_inst ? `ID_INST : `ID_DATA;
    assign wr_id  = wr_inst ? `ID_INST : `ID_DATA;

    assign inst_gnt = (rd_launch && rd_inst) || (wr_launch && wr_inst);
    assign data_gnt = (rd_launch && !rd_inst) || (wr_launch && !wr_inst);

    assign rready = 1'b1;
    assign bready = 1'b1;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else begin
            if (rd_launch) begin
                arvalid <= 1'b1;
            end else if (arready) begin
                arvalid <= 1'b0;
            end
            // aw and w leave together but retire on their own ready
            if (wr_launch) begin
                awvalid <= 1'b1;
                wvalid  <= 1'b1;
            end else begin
                if (awready) begin
                    awvalid <= 1'b0;
                end
                if (wready) begin
                    wvalid <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_launch) begin
            ar <= '{id: rd_id, addr: rd_sel.addr, size: rd_sel.size};
        end
        if (wr_launch) begin
            aw <= '{id: wr_id, addr: wr_sel.addr, size: wr_sel.size};
            w  <= '{data: wr_sel.wdata, strb: wr_sel.wstrb};
        end
    end

    // responses routed back by id
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            inst_done <= 1'b0;
            data_done <= 1'b0;
        end else begin
            inst_done <= rsp_hit(`ID_INST);
            data_done <= rsp_hit(`ID_DATA);
        end
    end

    always_ff @(posedge aclk) begin
        if (rsp_hit(`ID_INST)) begin
            inst_rsp <= rsp_pick(`ID_INST);
        end
        if (rsp_hit(`ID_DATA)) begin
            data_rsp <= rsp_pick(`ID_DATA);
        end
    end

    a_ar_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(ar));

endmodule

`default_nettype wire

//--- rtl/sram_port.sv
`default_nettype none
`include "mem_params.svh"

module sram_port
    import mem_pkg::*;
(
    input  logic       aclk,
    input  logic       rst_n,
    input  logic       req,
    input  sram_req_t  req_data,
    input  trans_cfg_t cfg,
    output logic       addr_ok,
    output logic       data_ok,
    output sram_rsp_t  rsp,
    output logic       bus_req,
    output sram_req_t  bus_data,
    input  logic       bus_gnt,
    input  logic       bus_done,
    input  sram_rsp_t  bus_rsp
);

    port_state_e        state;
    port_state_e        state_nxt;
    sram_req_t          req_q;
    trans_cfg_t         cfg_q;
    sram_rsp_t          rsp_q;
    logic [`ADDR_W-1:0] paddr;
    fault_e             trans_fault;

    addr_translate trans_i (
        .cfg   (cfg_q      ),
        .vaddr (req_q.addr ),
        .paddr (paddr      ),
        .fault (trans_fault)
    );

    assign addr_ok = (state == PS_IDLE);
    assign data_ok = (state == PS_DONE);
    assign rsp     = rsp_q;
    assign bus_req = (state == PS_ISSUE) && (trans_fault == FLT_NONE);

    always_comb begin
        bus_data      = req_q;
        bus_data.addr = paddr;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            PS_IDLE: begin
                if (req) begin
                    state_nxt = PS_ISSUE;
                end
            end
            PS_ISSUE: begin
                // faulted requests never reach the bus
                if (trans_fault != FLT_NONE) begin
                    state_nxt = PS_DONE;
                end else if (bus_gnt) begin
                    state_nxt = PS_WAIT;
                end
            end
            PS_WAIT: begin
                if (bus_done) begin
                    state_nxt = PS_DONE;
                end
            end
            default: begin
                state_nxt = PS_IDLE;
            end
        endcase
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= PS_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge aclk) begin
        if (addr_ok && req) begin
            req_q <= req_data;
            cfg_q <= cfg;
        end
        if (state == PS_ISSUE && trans_fault != FLT_NONE) begin
            rsp_q.rdata <= '0;
            rsp_q.fault <= trans_fault;
        end else if (state == PS_WAIT && bus_done) begin
            rsp_q <= bus_rsp;
        end
    end

    a_bus_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        bus_req && !bus_gnt |=> bus_req && $stable(bus_data));

    a_no_idle_data_ok: assert property (@(posedge aclk) disable iff (!rst_n)
        data_ok |-> $past(state) != PS_IDLE);

endmodule

`default_nettype wire

//--- rtl/addr_translate.sv
`default_nettype none
`include "mem_params.svh"

module addr_translate
    import mem_pkg::*;
(
    input  trans_cfg_t         cfg,
    input  logic [`ADDR_W-1:0] vaddr,
    output logic [`ADDR_W-1:0] paddr,
    output fault_e             fault
);

    logic [`SEG_BITS-1:0] vseg;
    logic                 mode_plv0;
    logic                 mode_plv3;
    logic                 hit0;
    logic                 hit1;

    assign vseg      = vaddr[`ADDR_W-1 -: `SEG_BITS];
    assign mode_plv0 = (cfg.plv == `PLV_W'd0);
    assign mode_plv3 = (cfg.plv == `PLV_W'd3);

    // window needs a segment match and the current level enabled
    assign hit0 = (cfg.dmw0.vseg == vseg) &&
                  ((cfg.dmw0.plv0 && mode_plv0) || (cfg.dmw0.plv3 && mode_plv3));
    assign hit1 = (cfg.dmw1.vseg == vseg) &&
                  ((cfg.dmw1.plv0 && mode_plv0) || (cfg.dmw1.plv3 && mode_plv3));

    always_comb begin
        paddr = vaddr;
        fault = FLT_NONE;
        if (!cfg.da) begin
            if (hit0) begin
                paddr = {cfg.dmw0.pseg, vaddr[`ADDR_W-`SEG_BITS-1:0]};
            end else if (hit1) begin
                paddr = {cfg.dmw1.pseg, vaddr[`ADDR_W-`SEG_BITS-1:0]};
            end else begin
                // paged, no tlb behind it
                fault = FLT_ADDR;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/mem_pkg.sv
`default_nettype none
`include "mem_params.svh"

package mem_pkg;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_e;

    typedef enum logic [1:0] {
        FLT_NONE = 2'd0,
        FLT_ADDR = 2'd1,
        FLT_BUS  = 2'd2
    } fault_e;

    typedef enum logic [1:0] {
        PS_IDLE  = 2'd0,
        PS_ISSUE = 2'd1,
        PS_WAIT  = 2'd2,
        PS_DONE  = 2'd3
    } port_state_e;

    // one direct-map window
    typedef struct packed {
        logic                 plv0;
        logic                 plv3;
        logic [`SEG_BITS-1:0] pseg;
        logic [`SEG_BITS-1:0] vseg;
    } dmw_t;

    typedef struct packed {
        logic              da;
        logic [`PLV_W-1:0] plv;
        dmw_t              dmw0;
        dmw_t              dmw1;
    } trans_cfg_t;

    typedef struct packed {
        bus_op_e             op;
        logic [2:0]          size;
        logic [3:0]          wstrb;
        logic [`ADDR_W-1:0]  addr;
        logic [`DATA_W-1:0]  wdata;
    } sram_req_t;

    typedef struct packed {
        logic [`DATA_W-1:0] rdata;
        fault_e             fault;
    } sram_rsp_t;

    // shared by ar and aw
    typedef struct packed {
        logic [`AXI_ID_W-1:0] id;
        logic [`ADDR_W-1:0]   addr;
        logic [2:0]           size;
    } axi_a_t;

    typedef struct packed {
        logic [`DATA_W-1:0] data;
        logic [3:0]         strb;
    } axi_w_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0] id;
        logic [`DATA_W-1:0]   data;
        logic [`RESP_W-1:0]   resp;
        logic                 last;
    } axi_r_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0] id;
        logic [`RESP_W-1:0]   resp;
    } axi_b_t;

endpackage

`default_nettype wire

//--- rtl/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// bus widths
`define DATA_W   32
`define ADDR_W   32
`define AXI_ID_W 4
`define RESP_W   2

// translation fields
`define SEG_BITS 3
`define PLV_W    2

// fixed axi id per requester
`define ID_INST  4'd0
`define ID_DATA  4'd1

`endif
